/* verilog.f */
+incdir+logic
logic/pcxt_pkg.sv
logic/clock_enable_gen.sv
logic/edge_strobe.sv
logic/reset_sequencer.sv
logic/splash_timer.sv
logic/sound_mixer.sv
logic/ppi_inputs.sv
logic/pcxt_glue_top.sv
verif/tb_pcxt_glue.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PC/XT glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module tb_pcxt_glue \
	-o tb_pcxt_glue

./obj_dir/tb_pcxt_glue | tee sim.log

if grep -qxF "*** TEST PASSED ***" sim.log; then
	echo "Simulation result: pass"
	exit 0
fi
echo "Simulation result: fail"
exit 1

/* verif/tb_pcxt_glue.sv */
// PC/XT glue testbench
`default_nettype none
`include "pcxt_defines.svh"

module tb_pcxt_glue;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD       = 100;
	localparam int DRIVE_DELAY      = 10;
	localparam int TB_TICKS_PER_SEC = 20;
	localparam int RATE_WINDOW      = 840;
	localparam int PULSE_COUNT      = 12;
	localparam int MIX_SAMPLES      = 24;

	// Cycle budget of each test
	localparam int RESET_TEST_CYCLES  = 16 + `PCXT_RESET_HOLD + `PCXT_CPU_RESET_DELAY;
	localparam int SPLASH_TEST_CYCLES =
		16 + `PCXT_SPLASH_SECONDS * TB_TICKS_PER_SEC * `PCXT_BASE_DIV;
	localparam int RATE_TEST_CYCLES   = 4 * (RATE_WINDOW + 1);
	localparam int TURBO_TEST_CYCLES  = 40;
	localparam int STROBE_TEST_CYCLES = PULSE_COUNT * 8 + 8;
	localparam int MIX_TEST_CYCLES    = MIX_SAMPLES + 16;
	localparam int WATCHDOG_CYCLES    = RESET_TEST_CYCLES + SPLASH_TEST_CYCLES +
		RATE_TEST_CYCLES + TURBO_TEST_CYCLES + STROBE_TEST_CYCLES + MIX_TEST_CYCLES + 5000;

	logic                     clk_chipset;
	logic                     reset_wire;
	pcxt_pkg::cpu_speed_t     cpu_speed;
	logic                     bus_idle;
	logic                     model_tandy;
	logic                     splash_skip;
	logic                     opl2_clk_in;
	logic                     uart_clk_in;
	pcxt_pkg::opl_sample_t    opl2_sample;
	logic                     speaker;
	pcxt_pkg::tandy_sample_t  tandy_sample;
	logic                     ps2_clk_in;
	logic                     ps2_data_in;
	logic                     mda_mode;
	logic                     port_b_bit3;
	logic                     cpu_tick;
	logic                     periph_tick;
	logic                     turbo;
	logic                     opl2_strobe;
	logic                     uart_strobe;
	logic                     sys_reset;
	logic                     cpu_reset;
	logic                     tandy_mode;
	logic                     splash_active;
	pcxt_pkg::audio_sample_t  audio_out;
	logic                     ps2_clk;
	logic                     ps2_data;
	pcxt_pkg::switch_nibble_t port_c_low;

	// Result bookkeeping
	int error_count;
	int tests_run;
	int tests_failed;
	// Strobe tallies for the edge test
	int opl2_strobe_count;
	int uart_strobe_count;

	pcxt_glue_top #(
		.TICKS_PER_SEC (TB_TICKS_PER_SEC)
	) DUT (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.cpu_speed     (cpu_speed),
		.bus_idle      (bus_idle),
		.model_tandy   (model_tandy),
		.splash_skip   (splash_skip),
		.opl2_clk_in   (opl2_clk_in),
		.uart_clk_in   (uart_clk_in),
		.opl2_sample   (opl2_sample),
		.speaker       (speaker),
		.tandy_sample  (tandy_sample),
		.ps2_clk_in    (ps2_clk_in),
		.ps2_data_in   (ps2_data_in),
		.mda_mode      (mda_mode),
		.port_b_bit3   (port_b_bit3),
		.cpu_tick      (cpu_tick),
		.periph_tick   (periph_tick),
		.turbo         (turbo),
		.opl2_strobe   (opl2_strobe),
		.uart_strobe   (uart_strobe),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.tandy_mode    (tandy_mode),
		.splash_active (splash_active),
		.audio_out     (audio_out),
		.ps2_clk       (ps2_clk),
		.ps2_data      (ps2_data),
		.port_c_low    (port_c_low)
	);

	////////////////////////////////////////
	// Clock, watchdog, strobe counters
	////////////////////////////////////////

	initial begin
		clk_chipset = 1'b0;
		forever #(CLK_PERIOD / 2) clk_chipset = ~clk_chipset;
	end

	// Hard stop if some wait never ends
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// Strobes sampled on the falling edge, away from updates
	always @(negedge clk_chipset) begin
		if (opl2_strobe)
			opl2_strobe_count++;
		if (uart_strobe)
			uart_strobe_count++;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Next drive point, just after the rising edge
	task automatic next_cycle();
		@(posedge clk_chipset);
		#(DRIVE_DELAY);
	endtask

	task automatic apply_reset();
		reset_wire = 1'b1;
		repeat (4) next_cycle();
		reset_wire = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	// Count compare with a tolerance
	task automatic check_count(input string name, input int got, input int exp,
		input int tol);
		int diff;
		diff = (got > exp) ? got - exp : exp - got;
		assert (diff <= tol) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (error_count == errs_before) begin
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: fail, %0d errors", name, error_count - errs_before);
		end
	endtask

	// Base ticks per CPU tick for a speed code
	function automatic int speed_divider(input int code);
		case (code)
			2:       return 1;
			1:       return 2;
			default: return 3;
		endcase
	endfunction

	// Turbo for 7.16 and 14.318 only
	function automatic logic turbo_expected(input int code);
		return (code == 1) || (code == 2);
	endfunction

	// 17-bit sum, upper 16 bits kept
	function automatic logic [15:0] mix_expected(input logic [15:0] fm, input logic spk,
		input logic [7:0] level);
		int          total;
		logic [31:0] total_bits;
		total      = $signed(fm) + (spk ? 16384 : 0) + int'(level) * 512;
		total_bits = total;
		return total_bits[16:1];
	endfunction

	task automatic drive_pulses(input bit uart_side, input int count);
		int high_len;
		int low_len;
		repeat (count) begin
			high_len = 1 + ($urandom % 4);
			low_len  = 1 + ($urandom % 4);
			if (uart_side)
				uart_clk_in = 1'b1;
			else
				opl2_clk_in = 1'b1;
			repeat (high_len) next_cycle();
			if (uart_side)
				uart_clk_in = 1'b0;
			else
				opl2_clk_in = 1'b0;
			repeat (low_len) next_cycle();
		end
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic run_reset_sequence();
		int errs_before;
		int n;
		errs_before = error_count;
		splash_skip = 1'b1;
		model_tandy = 1'b1;
		apply_reset();
		next_cycle();
		check_value("splash_active", splash_active, 32'd0);
		// Hold counts from the splash fall
		n = 0;
		while (sys_reset && n <= `PCXT_RESET_HOLD + 8) begin
			next_cycle();
			n++;
		end
		check_value("sys_reset release cycle", n, `PCXT_RESET_HOLD + 1);
		n = 0;
		while (cpu_reset && n <= `PCXT_CPU_RESET_DELAY + 8) begin
			next_cycle();
			n++;
		end
		check_value("cpu_reset release cycle", n, `PCXT_CPU_RESET_DELAY + 1);
		// Model is frozen once hold ends
		model_tandy = 1'b0;
		splash_skip = 1'b0;
		repeat (2) next_cycle();
		check_value("tandy_mode", tandy_mode, 32'd1);
		report_test("reset sequence", errs_before);
	endtask

	task automatic run_splash_length();
		int errs_before;
		int n;
		errs_before = error_count;
		splash_skip = 1'b0;
		apply_reset();
		n = 0;
		while (splash_active && n < SPLASH_TEST_CYCLES) begin
			next_cycle();
			n++;
		end
		check_count("splash_active high cycles", n,
			`PCXT_SPLASH_SECONDS * TB_TICKS_PER_SEC * `PCXT_BASE_DIV, `PCXT_BASE_DIV);
		report_test("splash length", errs_before);
	endtask

	task automatic run_clock_rates();
		int errs_before;
		int cpu_count;
		int periph_count;
		errs_before = error_count;
		for (int code = 0; code < 4; code++) begin
			cpu_speed = pcxt_pkg::cpu_speed_t'(2'(code));
			next_cycle();
			cpu_count    = 0;
			periph_count = 0;
			repeat (RATE_WINDOW) begin
				next_cycle();
				if (cpu_tick)
					cpu_count++;
				if (periph_tick)
					periph_count++;
			end
			check_count("cpu_tick count", cpu_count,
				RATE_WINDOW / (`PCXT_BASE_DIV * speed_divider(code)), 1);
			check_count("periph_tick count", periph_count,
				RATE_WINDOW / (`PCXT_BASE_DIV * 6), 1);
		end
		report_test("clock rates", errs_before);
	endtask

	task automatic run_turbo_flag();
		int   errs_before;
		int   speed_seq [4];
		int   n;
		logic held;
		logic exp;
		errs_before = error_count;
		// Each step flips the expected flag
		speed_seq[0] = 2;
		speed_seq[1] = 0;
		speed_seq[2] = 1;
		speed_seq[3] = 3;
		bus_idle  = 1'b1;
		cpu_speed = pcxt_pkg::SPEED_4_77;
		repeat (2) next_cycle();
		check_value("turbo", turbo, 32'd0);
		held = 1'b0;
		foreach (speed_seq[i]) begin
			exp       = turbo_expected(speed_seq[i]);
			bus_idle  = 1'b0;
			cpu_speed = pcxt_pkg::cpu_speed_t'(2'(speed_seq[i]));
			repeat (4) begin
				next_cycle();
				check_value("turbo while busy", turbo, held);
			end
			bus_idle = 1'b1;
			n = 0;
			while (turbo !== exp && n < 2) begin
				next_cycle();
				n++;
			end
			check_value("turbo", turbo, exp);
			held = exp;
		end
		report_test("turbo flag", errs_before);
	endtask

	task automatic run_edge_strobes();
		int errs_before;
		errs_before       = error_count;
		opl2_strobe_count = 0;
		uart_strobe_count = 0;
		fork
			drive_pulses(1'b0, PULSE_COUNT);
			drive_pulses(1'b1, PULSE_COUNT);
		join
		// Let the last strobes through the synchroniser
		repeat (6) next_cycle();
		check_value("opl2_strobe count", opl2_strobe_count, PULSE_COUNT);
		check_value("uart_strobe count", uart_strobe_count, PULSE_COUNT);
		report_test("edge strobes", errs_before);
	endtask

	task automatic run_mixer_inputs();
		int          errs_before;
		logic [31:0] rnd;
		logic [15:0] exp_audio;
		logic [7:0]  sw;
		logic [3:0]  exp_nib;
		logic        prev_clk;
		logic        prev_data;
		errs_before = error_count;
		repeat (MIX_SAMPLES) begin
			rnd          = $urandom;
			opl2_sample  = rnd[15:0];
			tandy_sample = rnd[23:16];
			speaker      = rnd[24];
			exp_audio    = mix_expected(rnd[15:0], rnd[24], rnd[23:16]);
			next_cycle();
			check_value("audio_out", audio_out[15:0], exp_audio);
		end
		// All four switch selections
		for (int m = 0; m < 2; m++) begin
			for (int b = 0; b < 2; b++) begin
				mda_mode    = m[0];
				port_b_bit3 = b[0];
				sw          = m[0] ? `PCXT_SW_MDA : `PCXT_SW_CGA;
				exp_nib     = b[0] ? sw[7:4] : sw[3:0];
				next_cycle();
				check_value("port_c_low", port_c_low, exp_nib);
			end
		end
		// PS/2 lines two cycles behind
		repeat (4) begin
			rnd         = $urandom;
			prev_clk    = ps2_clk_in;
			prev_data   = ps2_data_in;
			ps2_clk_in  = ~ps2_clk_in;
			ps2_data_in = rnd[0];
			next_cycle();
			check_value("ps2_clk early", ps2_clk, prev_clk);
			check_value("ps2_data early", ps2_data, prev_data);
			next_cycle();
			check_value("ps2_clk", ps2_clk, ps2_clk_in);
			check_value("ps2_data", ps2_data, ps2_data_in);
		end
		report_test("mixer and inputs", errs_before);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(32'h9ea9));
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset_wire   = 1'b1;
		cpu_speed    = pcxt_pkg::SPEED_4_77;
		bus_idle     = 1'b1;
		model_tandy  = 1'b0;
		splash_skip  = 1'b0;
		opl2_clk_in  = 1'b0;
		uart_clk_in  = 1'b0;
		opl2_sample  = '0;
		speaker      = 1'b0;
		tandy_sample = '0;
		ps2_clk_in   = 1'b0;
		ps2_data_in  = 1'b0;
		mda_mode     = 1'b0;
		port_b_bit3  = 1'b0;

		run_reset_sequence();
		run_splash_length();
		run_clock_rates();
		run_turbo_flag();
		run_edge_strobes();
		run_mixer_inputs();

		$display("Tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/pcxt_glue_top.sv */
// PC/XT chipset glue top
`default_nettype none
`include "pcxt_defines.svh"

module pcxt_glue_top #(
	parameter int TICKS_PER_SEC = `PCXT_SPLASH_TICKS_PER_SEC
) (
	input  wire                          clk_chipset,
	input  wire                          reset_wire,
	input  wire pcxt_pkg::cpu_speed_t    cpu_speed,
	input  wire                          bus_idle,
	input  wire                          model_tandy,
	input  wire                          splash_skip,
	input  wire                          opl2_clk_in,
	input  wire                          uart_clk_in,
	input  wire pcxt_pkg::opl_sample_t   opl2_sample,
	input  wire                          speaker,
	input  wire pcxt_pkg::tandy_sample_t tandy_sample,
	input  wire                          ps2_clk_in,
	input  wire                          ps2_data_in,
	input  wire                          mda_mode,
	input  wire                          port_b_bit3,
	output logic                         cpu_tick,
	output logic                         periph_tick,
	output logic                         turbo,
	output logic                         opl2_strobe,
	output logic                         uart_strobe,
	output logic                         sys_reset,
	output logic                         cpu_reset,
	output logic                         tandy_mode,
	output logic                         splash_active,
	output pcxt_pkg::audio_sample_t      audio_out,
	output logic                         ps2_clk,
	output logic                         ps2_data,
	output pcxt_pkg::switch_nibble_t     port_c_low
);

	// Base enable feeds the splash count
	logic tick_14_318;

	////////////////////////////////////////
	// Clocking
	////////////////////////////////////////

	clock_enable_gen u_clock_enable_gen (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.cpu_speed   (cpu_speed),
		.bus_idle    (bus_idle),
		.tick_14_318 (tick_14_318),
		.cpu_tick    (cpu_tick),
		.periph_tick (periph_tick),
		.turbo       (turbo)
	);

	// FM synth clock
	edge_strobe u_opl2_strobe (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.async_clk   (opl2_clk_in),
		.strobe      (opl2_strobe)
	);

	// UART baud clock
	edge_strobe u_uart_strobe (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.async_clk   (uart_clk_in),
		.strobe      (uart_strobe)
	);

	////////////////////////////////////////
	// Reset and splash
	////////////////////////////////////////

	splash_timer #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_splash_timer (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.tick_14_318   (tick_14_318),
		.splash_skip   (splash_skip),
		.splash_active (splash_active)
	);

	reset_sequencer u_reset_sequencer (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.splash_active (splash_active),
		.model_tandy   (model_tandy),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.tandy_mode    (tandy_mode)
	);

	////////////////////////////////////////
	// Audio and inputs
	////////////////////////////////////////

	sound_mixer u_sound_mixer (
		.clk_chipset  (clk_chipset),
		.reset_wire   (reset_wire),
		.opl2_sample  (opl2_sample),
		.speaker      (speaker),
		.tandy_sample (tandy_sample),
		.audio_out    (audio_out)
	);

	ppi_inputs u_ppi_inputs (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.ps2_clk_in  (ps2_clk_in),
		.ps2_data_in (ps2_data_in),
		.mda_mode    (mda_mode),
		.port_b_bit3 (port_b_bit3),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.port_c_low  (port_c_low)
	);

endmodule

`default_nettype wire

/* logic/ppi_inputs.sv */
// Keyboard and DIP switch inputs
`default_nettype none
`include "pcxt_defines.svh"

module ppi_inputs (
	input  wire                      clk_chipset,
	input  wire                      reset_wire,
	input  wire                      ps2_clk_in,
	input  wire                      ps2_data_in,
	input  wire                      mda_mode,
	input  wire                      port_b_bit3,
	output logic                     ps2_clk,
	output logic                     ps2_data,
	output pcxt_pkg::switch_nibble_t port_c_low
);

	////////////////////////////////////////
	// PS/2 synchronisers
	////////////////////////////////////////

	logic ps2_clk_meta;
	logic ps2_data_meta;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			ps2_clk_meta  <= 1'b0;
			ps2_clk       <= 1'b0;
			ps2_data_meta <= 1'b0;
			ps2_data      <= 1'b0;
		end else begin
			ps2_clk_meta  <= ps2_clk_in;
			ps2_clk       <= ps2_clk_meta;
			ps2_data_meta <= ps2_data_in;
			ps2_data      <= ps2_data_meta;
		end
	end

	////////////////////////////////////////
	// DIP switches on port C
	////////////////////////////////////////

	logic [7:0] sw_byte;

	// Switch set per monitor card
	assign sw_byte = mda_mode ? `PCXT_SW_MDA : `PCXT_SW_CGA;

	// Port B bit 3 picks the half
	assign port_c_low = port_b_bit3 ? sw_byte[7:4] : sw_byte[3:0];

endmodule

`default_nettype wire

/* logic/sound_mixer.sv */
// Signed audio mixer
`default_nettype none

module sound_mixer (
	input  wire                          clk_chipset,
	input  wire                          reset_wire,
	input  wire pcxt_pkg::opl_sample_t   opl2_sample,
	input  wire                          speaker,
	input  wire pcxt_pkg::tandy_sample_t tandy_sample,
	output pcxt_pkg::audio_sample_t      audio_out
);

	// One bit of headroom over the output
	logic signed [16:0] fm_term;
	logic signed [16:0] spk_term;
	logic signed [16:0] tandy_term;
	logic signed [16:0] mix_sum;

	// Sign extend FM
	assign fm_term    = {opl2_sample[15], opl2_sample};
	// Speaker at 2^14
	assign spk_term   = {2'b00, speaker, 14'd0};
	// Tandy level at 2^9
	assign tandy_term = {tandy_sample, 9'd0};

	assign mix_sum = fm_term + spk_term + tandy_term;

	// Drop the LSB to halve
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			audio_out <= '0;
		else
			audio_out <= mix_sum[16:1];
	end

endmodule

`default_nettype wire

/* logic/splash_timer.sv */
// Splash screen timer
`default_nettype none
`include "pcxt_defines.svh"

module splash_timer #(
	parameter int TICKS_PER_SEC = `PCXT_SPLASH_TICKS_PER_SEC
) (
	input  wire  clk_chipset,
	input  wire  reset_wire,
	input  wire  tick_14_318,
	input  wire  splash_skip,
	output logic splash_active
);

	localparam int SEC_W = $clog2(`PCXT_SPLASH_SECONDS + 1);
	localparam pcxt_pkg::splash_count_t SUB_LAST =
		pcxt_pkg::splash_count_t'(TICKS_PER_SEC - 1);
	localparam logic [SEC_W-1:0] SEC_LAST = SEC_W'(`PCXT_SPLASH_SECONDS - 1);

	// Base ticks within the current second
	pcxt_pkg::splash_count_t sub_cnt;
	logic [SEC_W-1:0]        sec_cnt;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sub_cnt       <= '0;
			sec_cnt       <= '0;
			splash_active <= 1'b1;
		end else if (splash_active) begin
			if (splash_skip) begin
				splash_active <= 1'b0;
			end else if (tick_14_318) begin
				if (sub_cnt == SUB_LAST) begin
					sub_cnt <= '0;
					// Last second done
					if (sec_cnt == SEC_LAST)
						splash_active <= 1'b0;
					else
						sec_cnt <= sec_cnt + 1'b1;
				end else begin
					sub_cnt <= sub_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/reset_sequencer.sv */
// System and CPU reset sequencer
`default_nettype none
`include "pcxt_defines.svh"

module reset_sequencer (
	input  wire  clk_chipset,
	input  wire  reset_wire,
	input  wire  splash_active,
	input  wire  model_tandy,
	output logic sys_reset,
	output logic cpu_reset,
	output logic tandy_mode
);

	localparam pcxt_pkg::reset_count_t HOLD_LAST =
		pcxt_pkg::reset_count_t'(`PCXT_RESET_HOLD);
	localparam pcxt_pkg::reset_count_t DELAY_LAST =
		pcxt_pkg::reset_count_t'(`PCXT_CPU_RESET_DELAY);

	pcxt_pkg::reset_state_t state;
	// Shared by hold and CPU delay
	pcxt_pkg::reset_count_t count;

	////////////////////////////////////////
	// Sequencer FSM
	////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			state     <= pcxt_pkg::RST_HOLD;
			count     <= '0;
			sys_reset <= 1'b1;
			cpu_reset <= 1'b1;
		end else if (splash_active) begin
			// Splash keeps the machine parked in hold
			state     <= pcxt_pkg::RST_HOLD;
			count     <= '0;
			sys_reset <= 1'b1;
			cpu_reset <= 1'b1;
		end else begin
			case (state)
				pcxt_pkg::RST_HOLD: begin
					// Long hold for memory and chipset
					if (count == HOLD_LAST) begin
						state     <= pcxt_pkg::RST_CPU_WAIT;
						count     <= '0;
						sys_reset <= 1'b0;
					end else begin
						count <= count + 1'b1;
					end
				end
				pcxt_pkg::RST_CPU_WAIT: begin
					// Short delay before CPU runs
					if (count == DELAY_LAST) begin
						state     <= pcxt_pkg::RST_RUN;
						cpu_reset <= 1'b0;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: begin
					// Running, nothing moves
					count <= count;
				end
			endcase
		end
	end

	// Model follows the switch until hold ends
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			tandy_mode <= 1'b0;
		else if (sys_reset)
			tandy_mode <= model_tandy;
	end

	// CPU never leaves reset ahead of the chipset
	a_reset_order: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		!(sys_reset && !cpu_reset));

endmodule

`default_nettype wire

/* logic/edge_strobe.sv */
// External clock edge strobe
`default_nettype none

module edge_strobe (
	input  wire  clk_chipset,
	input  wire  reset_wire,
	input  wire  async_clk,
	output logic strobe
);

	// Two stage synchroniser
	logic sync_1;
	logic sync_2;
	// Previous synchronised level
	logic sync_hist;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sync_1    <= 1'b0;
			sync_2    <= 1'b0;
			sync_hist <= 1'b0;
			strobe    <= 1'b0;
		end else begin
			sync_1    <= async_clk;
			sync_2    <= sync_1;
			sync_hist <= sync_2;
			// Rising edge only
			strobe    <= sync_2 & ~sync_hist;
		end
	end

	a_strobe_single: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		strobe |=> !strobe);

endmodule

`default_nettype wire

/* logic/clock_enable_gen.sv */
// Chipset clock enables
`default_nettype none
`include "pcxt_defines.svh"

module clock_enable_gen (
	input  wire                        clk_chipset,
	input  wire                        reset_wire,
	input  wire pcxt_pkg::cpu_speed_t  cpu_speed,
	input  wire                        bus_idle,
	output logic                       tick_14_318,
	output logic                       cpu_tick,
	output logic                       periph_tick,
	output logic                       turbo
);

	localparam int BASE_W = $clog2(`PCXT_BASE_DIV);
	localparam logic [BASE_W-1:0] BASE_LAST = BASE_W'(`PCXT_BASE_DIV - 1);

	logic [BASE_W-1:0] base_cnt;
	// Position within six base ticks
	logic [2:0]        phase;
	logic              tick_7_16;
	logic              tick_4_77;

	////////////////////////////////////////
	// Base 14.318 MHz enable
	////////////////////////////////////////

	// First pulse lands BASE_DIV cycles out of reset
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			base_cnt    <= '0;
			tick_14_318 <= 1'b0;
		end else if (base_cnt == BASE_LAST) begin
			base_cnt    <= '0;
			tick_14_318 <= 1'b1;
		end else begin
			base_cnt    <= base_cnt + 1'b1;
			tick_14_318 <= 1'b0;
		end
	end

	// Advance once per base tick, wrap at six
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			phase <= '0;
		end else if (tick_14_318) begin
			if (phase == 3'd5)
				phase <= '0;
			else
				phase <= phase + 3'd1;
		end
	end

	////////////////////////////////////////
	// Derived rates
	////////////////////////////////////////

	// Half rate on even phases
	assign tick_7_16   = tick_14_318 & ~phase[0];
	// Third rate
	assign tick_4_77   = tick_14_318 & ((phase == 3'd0) | (phase == 3'd3));
	// Sixth rate, 2.385 MHz
	assign periph_tick = tick_14_318 & (phase == 3'd0);

	// CPU rate mux, unused code runs at 4.77
	always_comb begin
		case (cpu_speed)
			pcxt_pkg::SPEED_14_318: cpu_tick = tick_14_318;
			pcxt_pkg::SPEED_7_16:   cpu_tick = tick_7_16;
			default:                cpu_tick = tick_4_77;
		endcase
	end

	// Turbo only moves between bus cycles
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			turbo <= 1'b0;
		else if (bus_idle)
			turbo <= (cpu_speed == pcxt_pkg::SPEED_7_16) ||
			         (cpu_speed == pcxt_pkg::SPEED_14_318);
	end

	// Enables are single cycle
	a_tick_single: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		(tick_14_318 | cpu_tick | periph_tick) |=> !(tick_14_318 | cpu_tick | periph_tick));

endmodule

`default_nettype wire

/* logic/pcxt_pkg.sv */
// PC/XT glue types
`default_nettype none

package pcxt_pkg;

	// CPU rate select, value 3 falls back to 4.77
	typedef enum logic [1:0] {
		SPEED_4_77   = 2'd0,
		SPEED_7_16   = 2'd1,
		SPEED_14_318 = 2'd2
	} cpu_speed_t;

	// Reset sequencer states
	typedef enum logic [1:0] {
		RST_HOLD     = 2'd0,
		RST_CPU_WAIT = 2'd1,
		RST_RUN      = 2'd2
	} reset_state_t;

	typedef logic [15:0]        reset_count_t;
	typedef logic [24:0]        splash_count_t;
	typedef logic signed [15:0] opl_sample_t;
	typedef logic [7:0]         tandy_sample_t;
	typedef logic signed [15:0] audio_sample_t;
	typedef logic [3:0]         switch_nibble_t;

endpackage

`default_nettype wire

/* logic/pcxt_defines.svh */
// PC/XT glue constants
`ifndef PCXT_DEFINES_SVH
`define PCXT_DEFINES_SVH

// clk_chipset cycles per 14.318 MHz enable
`define PCXT_BASE_DIV 7

// System reset hold length in cycles
`define PCXT_RESET_HOLD 65535

// Cycles from system reset release to CPU reset release, less one
`define PCXT_CPU_RESET_DELAY 42

// Splash screen length in seconds
`define PCXT_SPLASH_SECONDS 5

// Base ticks in one second
`define PCXT_SPLASH_TICKS_PER_SEC 14318000

// DIP switch bytes per monitor type
// MDA 80 column
`define PCXT_SW_MDA 8'h3D
// CGA 80 column
`define PCXT_SW_CGA 8'h2D

`endif
